// File: flist.f
verilog/uart_pkg.sv
verilog/uart_regs.sv
verilog/uart_tx.sv
verilog/uart_rx.sv
verilog/uart_periph.sv
tb/uart_periph_tb.sv

// File: Makefile
# Verilator simulation of the UART peripheral testbench

VERILATOR ?= verilator
TOP       ?= uart_periph_tb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
FAIL_MSG  ?= >>> FAIL

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q -F -- '$(FAIL_MSG)' $(LOG); then \
		echo "sim: failure found in $(LOG)"; exit 1; \
	fi; \
	exit $$status

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: tb/uart_periph_tb.sv
`timescale 1ns/10ps

module uart_periph_tb;

    localparam int brr_width   = 16;
    localparam int baud_div    = 16;  // Clock cycles per bit
    localparam int max_frames  = 63;  // 3 formats x 10 rounds x 2 bytes, plus 3
    localparam int watchdog_ns = max_frames * 12 * baud_div * 20 + 50_000;
    localparam int poll_limit  = 500;

    logic            seq;
    logic            arst_n;
    logic            psel;
    logic            penable;
    logic            pwrite;
    uart_pkg::addr_t paddr;
    uart_pkg::data_t pwdata;
    logic [3:0]      pstrb;
    uart_pkg::data_t prdata;
    logic            pready;
    logic            pslverr;
    logic            irq;
    logic            line;  // tx looped back to rx

    int          error_count;
    int          check_count;
    logic [31:0] lcg_state;
    string       cur_test;

    uart_periph #(
        .BRR_WIDTH (brr_width)
    ) i_uart_periph (
        .seq     (seq),
        .arst_n  (arst_n),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .pstrb   (pstrb),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .irq     (irq),
        .tx      (line),
        .rx      (line)
    );

    always #10 seq = ~seq;

    function automatic logic [7:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[23:16];  // Middle bits, better spread
    endfunction

    function automatic uart_pkg::data_t make_ctrl(input int data_bits,
                                                  input uart_pkg::parity_e parity,
                                                  input logic two_stop);
        uart_pkg::ctrl_t c;
        c           = '0;
        c.periph_en = 1'b1;
        c.tx_en     = 1'b1;
        c.rx_en     = 1'b1;
        c.parity    = parity;
        c.two_stop  = two_stop;
        c.data_bits = 4'(data_bits);
        return {20'b0, c};
    endfunction

    // Error flags are expected clear in every test here
    function automatic uart_pkg::status_t make_status(input logic tbe, input logic rbf,
                                                      input logic overrun);
        uart_pkg::status_t s;
        s         = '0;
        s.tbe     = tbe;
        s.rbf     = rbf;
        s.overrun = overrun;
        return s;
    endfunction

    // Setup phase, access phase, then bus idle
    task automatic bus_cycle(input logic write, input uart_pkg::addr_t addr,
                             input uart_pkg::data_t wdata,
                             output uart_pkg::data_t rdata, output logic resp);
        @(posedge seq);
        #2;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = wdata;
        pstrb   = 4'hF;
        @(posedge seq);
        #2;
        penable = 1'b1;
        @(negedge seq);
        check_resp({cur_test, " pready"}, 1'b1, pready);  // No wait states
        rdata = prdata;
        resp  = pslverr;
        @(posedge seq);
        #2;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_write(input uart_pkg::addr_t addr, input uart_pkg::data_t data,
                             output logic resp);
        uart_pkg::data_t unused;
        bus_cycle(1'b1, addr, data, unused, resp);
    endtask

    task automatic apb_read(input uart_pkg::addr_t addr, output uart_pkg::data_t data,
                            output logic resp);
        bus_cycle(1'b0, addr, 32'h0, data, resp);
    endtask

    task automatic check_word(input string name, input uart_pkg::data_t exp,
                              input uart_pkg::data_t act);
        check_count++;
        if (act !== exp) begin
            error_count++;
            $display("mismatch %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_resp(input string name, input logic exp, input logic act);
        check_count++;
        if (act !== exp) begin
            error_count++;
            $display("mismatch %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic check_status(input string name, input uart_pkg::status_t exp,
                                input uart_pkg::status_t act);
        check_count++;
        if (act !== exp) begin
            error_count++;
            $display("mismatch %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic wait_flag(input string name, input uart_pkg::status_t mask);
        uart_pkg::data_t rdata;
        logic            resp;
        int              polls;
        polls = 0;
        do begin
            apb_read(uart_pkg::reg_sr, rdata, resp);
            polls++;
        end while ((rdata[4:0] & mask) == 5'b0 && polls < poll_limit);
        if ((rdata[4:0] & mask) == 5'b0) begin
            error_count++;
            $display("%s: status flag %b still clear after %0d polls", name, mask, polls);
        end
    endtask

    // Line counts as idle after a stretch longer than any all-high bit run
    task automatic wait_idle();
        int high_cycles;
        high_cycles = 0;
        while (high_cycles < 12 * baud_div) begin
            @(negedge seq);
            high_cycles = line ? high_cycles + 1 : 0;
        end
    endtask

    task automatic write_read(input string name, input uart_pkg::addr_t addr,
                              input uart_pkg::data_t wdata, input uart_pkg::data_t exp);
        uart_pkg::data_t rdata;
        logic            resp;
        apb_write(addr, wdata, resp);
        check_resp({name, " write"}, uart_pkg::resp_okay, resp);
        apb_read(addr, rdata, resp);
        check_resp({name, " read"}, uart_pkg::resp_okay, resp);
        check_word(name, exp, rdata);
    endtask

    task automatic test_regs();
        write_read("test_regs brr", uart_pkg::reg_brr, 32'(baud_div), 32'(baud_div));
        write_read("test_regs cr", uart_pkg::reg_cr, 32'h0000_0807, 32'h0000_0807);
        write_read("test_regs ier", uart_pkg::reg_ier, 32'hFFFF_FFFF, 32'h0000_001F);
    endtask

    task automatic test_disabled();
        uart_pkg::data_t rdata;
        logic            resp;
        apb_write(uart_pkg::reg_cr, 32'h0, resp);
        check_resp("test_disabled cr", uart_pkg::resp_okay, resp);
        apb_read(uart_pkg::reg_dr, rdata, resp);
        check_resp("test_disabled dr read", uart_pkg::resp_slverr, resp);
        apb_write(uart_pkg::reg_dr, 32'h0000_0055, resp);
        check_resp("test_disabled dr write", uart_pkg::resp_slverr, resp);
        apb_read(32'h0000_0014, rdata, resp);
        check_resp("test_disabled unmapped", uart_pkg::resp_slverr, resp);
        check_word("test_disabled unmapped data", 32'h0, rdata);
        apb_read(uart_pkg::reg_sr, rdata, resp);  // Rejected write left tbe alone
        check_status("test_disabled sr", make_status(1'b1, 1'b0, 1'b0),
                     uart_pkg::status_t'(rdata[4:0]));
    endtask

    task automatic test_irq();
        logic resp;
        apb_write(uart_pkg::reg_ier, 32'h0, resp);
        repeat (2) @(negedge seq);  // irq is one cycle behind the registers
        check_resp("test_irq disabled", 1'b0, irq);
        apb_write(uart_pkg::reg_ier, 32'h0000_0001, resp);
        repeat (2) @(negedge seq);
        check_resp("test_irq tbe", 1'b1, irq);
        apb_write(uart_pkg::reg_ier, 32'h0, resp);
    endtask

    task automatic run_format(input string name, input int data_bits,
                              input uart_pkg::parity_e parity, input logic two_stop);
        uart_pkg::data_t rdata;
        logic            resp;
        logic [7:0]      sent[$];
        logic [7:0]      mask;
        logic [7:0]      b;
        logic [7:0]      exp_byte;
        int              nbytes;
        mask = 8'((1 << data_bits) - 1);
        apb_write(uart_pkg::reg_cr, make_ctrl(data_bits, parity, two_stop), resp);
        check_resp(name, uart_pkg::resp_okay, resp);
        for (int round = 0; round < 10; round++) begin
            b      = lcg_next();
            nbytes = b[0] ? 2 : 1;
            for (int i = 0; i < nbytes; i++) begin
                b = lcg_next();
                wait_flag(name, make_status(1'b1, 1'b0, 1'b0));
                apb_write(uart_pkg::reg_dr, {24'b0, b}, resp);
                check_resp(name, uart_pkg::resp_okay, resp);
                sent.push_back(b & mask);  // Receiver zero-fills the high bits
            end
            while (sent.size() > 0) begin
                wait_flag(name, make_status(1'b0, 1'b1, 1'b0));
                apb_read(uart_pkg::reg_dr, rdata, resp);
                exp_byte = sent.pop_front();
                check_word(name, {24'b0, exp_byte}, rdata);
            end
        end
        wait_idle();
        apb_read(uart_pkg::reg_sr, rdata, resp);
        check_status(name, make_status(1'b1, 1'b0, 1'b0), uart_pkg::status_t'(rdata[4:0]));
    endtask

    task automatic test_loopback();
        logic resp;
        apb_write(uart_pkg::reg_brr, 32'(baud_div), resp);
        run_format("test_loopback 8N1", 8, uart_pkg::parity_none, 1'b0);
        run_format("test_loopback 7E2", 7, uart_pkg::parity_even, 1'b1);
        run_format("test_loopback 5O1", 5, uart_pkg::parity_odd, 1'b0);
    endtask

    task automatic test_overrun();
        uart_pkg::data_t rdata;
        logic            resp;
        logic [7:0]      bytes[3];
        for (int i = 0; i < 3; i++) begin
            bytes[i] = lcg_next();
        end
        apb_write(uart_pkg::reg_cr, make_ctrl(8, uart_pkg::parity_none, 1'b0), resp);
        // First goes on the line, second waits in the buffer, third is dropped
        for (int i = 0; i < 3; i++) begin
            apb_write(uart_pkg::reg_dr, {24'b0, bytes[i]}, resp);
        end
        wait_idle();
        apb_read(uart_pkg::reg_sr, rdata, resp);
        check_status("test_overrun sr", make_status(1'b1, 1'b1, 1'b1),
                     uart_pkg::status_t'(rdata[4:0]));
        apb_read(uart_pkg::reg_dr, rdata, resp);
        check_word("test_overrun dr", {24'b0, bytes[1]}, rdata);
        apb_write(uart_pkg::reg_sr, 32'h0000_0010, resp);
        apb_read(uart_pkg::reg_sr, rdata, resp);
        check_status("test_overrun clear", make_status(1'b1, 1'b0, 1'b0),
                     uart_pkg::status_t'(rdata[4:0]));
    endtask

    initial begin
        seq         = 1'b0;
        arst_n      = 1'b0;
        psel        = 1'b0;
        penable     = 1'b0;
        pwrite      = 1'b0;
        paddr       = '0;
        pwdata      = '0;
        pstrb       = 4'h0;
        error_count = 0;
        check_count = 0;
        lcg_state   = 32'd63;
        cur_test    = "reset";
        repeat (8) @(posedge seq);
        #2;
        arst_n = 1'b1;
        cur_test = "test_regs";
        test_regs();
        cur_test = "test_disabled";
        test_disabled();
        cur_test = "test_irq";
        test_irq();
        cur_test = "test_loopback";
        test_loopback();
        cur_test = "test_overrun";
        test_overrun();
        $display("%0d checks, %0d errors", check_count, error_count);
        if (error_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(watchdog_ns);
        $display("timeout: run hung, still going after %0d ns", watchdog_ns);
        $display(">>> FAIL");
        $finish;
    end

endmodule

// File: verilog/uart_periph.sv
`timescale 1ns/10ps

module uart_periph #(
    parameter int BRR_WIDTH = 16
) (
    input  logic            seq,
    input  logic            arst_n,
    input  logic            psel,
    input  logic            penable,
    input  logic            pwrite,
    input  uart_pkg::addr_t paddr,
    input  uart_pkg::data_t pwdata,
    input  logic [3:0]      pstrb,
    output uart_pkg::data_t prdata,
    output logic            pready,
    output logic            pslverr,
    output logic            irq,
    output logic            tx,
    input  logic            rx
);

    uart_pkg::ctrl_t      ctrl;
    logic [BRR_WIDTH-1:0] brr;
    uart_pkg::tx_req_t    tx_req;
    logic                 tx_ready;
    uart_pkg::rx_frame_t  rx_frame;

    // Register file and buffers
    uart_regs #(
        .BRR_WIDTH (BRR_WIDTH)
    ) i_uart_regs (
        .seq      (seq),
        .arst_n   (arst_n),
        .psel     (psel),
        .penable  (penable),
        .pwrite   (pwrite),
        .paddr    (paddr),
        .pwdata   (pwdata),
        .pstrb    (pstrb),
        .prdata   (prdata),
        .pready   (pready),
        .pslverr  (pslverr),
        .ctrl     (ctrl),
        .brr      (brr),
        .tx_req   (tx_req),
        .tx_ready (tx_ready),
        .rx_frame (rx_frame),
        .irq      (irq)
    );

    uart_tx #(
        .BRR_WIDTH (BRR_WIDTH)
    ) i_uart_tx (
        .seq      (seq),
        .arst_n   (arst_n),
        .ctrl     (ctrl),
        .brr      (brr),
        .tx_req   (tx_req),
        .tx_ready (tx_ready),
        .tx       (tx)
    );

    uart_rx #(
        .BRR_WIDTH (BRR_WIDTH)
    ) i_uart_rx (
        .seq      (seq),
        .arst_n   (arst_n),
        .ctrl     (ctrl),
        .brr      (brr),
        .rx       (rx),
        .rx_frame (rx_frame)
    );

endmodule

// File: verilog/uart_rx.sv
`timescale 1ns/10ps

module uart_rx #(
    parameter int BRR_WIDTH = 16
) (
    input  logic                 seq,
    input  logic                 arst_n,
    input  uart_pkg::ctrl_t      ctrl,
    input  logic [BRR_WIDTH-1:0] brr,
    input  logic                 rx,
    output uart_pkg::rx_frame_t  rx_frame
);

    typedef enum logic [2:0] {
        st_idle,
        st_start,
        st_data,
        st_parity,
        st_stop,
        st_stop2
    } state_t;

    state_t               state;
    logic [BRR_WIDTH-1:0] baud_cnt;
    logic [3:0]           bit_cnt;
    logic [3:0]           nbits;
    logic                 rx_meta, rx_sync, rx_prev;
    logic                 bit_done, half_done, restart;
    logic                 frame_end;
    logic [7:0]           shift;
    logic                 par, perr, ferr;
    logic                 valid_q;
    logic [7:0]           frame_data;
    logic                 frame_perr, frame_ferr;

    assign nbits     = uart_pkg::frame_bits(ctrl);
    assign bit_done  = (brr == '0) || (baud_cnt == brr - BRR_WIDTH'(1));
    assign half_done = ((brr >> 1) == '0) || (baud_cnt == (brr >> 1) - BRR_WIDTH'(1));
    assign restart   = (state == st_idle) || ((state == st_start) ? half_done : bit_done);
    assign frame_end = bit_done && ((state == st_stop && !ctrl.two_stop) ||
                                    state == st_stop2);

    // Two-flop synchronizer plus edge history
    always_ff @(posedge seq or negedge arst_n) begin
        if (!arst_n) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    always_ff @(posedge seq or negedge arst_n) begin
        if (!arst_n) begin
            state    <= st_idle;
            baud_cnt <= '0;
            bit_cnt  <= '0;
            valid_q  <= 1'b0;
        end else begin
            baud_cnt <= restart ? '0 : baud_cnt + BRR_WIDTH'(1);
            valid_q  <= frame_end;
            case (state)
                st_idle: begin
                    if (rx_prev && !rx_sync && ctrl.periph_en && ctrl.rx_en) state <= st_start;
                end
                st_start: begin
                    if (half_done) begin
                        state   <= rx_sync ? st_idle : st_data; // Glitch, not a start bit
                        bit_cnt <= '0;
                    end
                end
                st_data: begin
                    if (bit_done) begin
                        bit_cnt <= bit_cnt + 4'd1;
                        if (bit_cnt == nbits - 4'd1) begin
                            state <= uart_pkg::has_parity(ctrl) ? st_parity : st_stop;
                        end
                    end
                end
                st_parity: if (bit_done) state <= st_stop;
                st_stop:   if (bit_done) state <= ctrl.two_stop ? st_stop2 : st_idle;
                st_stop2:  if (bit_done) state <= st_idle;
                default:   state <= st_idle;
            endcase
        end
    end

    // Mid-bit samples and checks
    always_ff @(posedge seq) begin
        if (state == st_start && half_done) begin
            shift <= '0; // Unused high bits stay zero
            par   <= (ctrl.parity == uart_pkg::parity_odd);
            perr  <= 1'b0;
        end
        if (state == st_data && bit_done) begin
            shift[bit_cnt[2:0]] <= rx_sync;
            par                 <= par ^ rx_sync;
        end
        if (state == st_parity && bit_done) perr <= (rx_sync != par);
        if (state == st_stop && bit_done) ferr <= !rx_sync;  // First stop bit only
        if (frame_end) begin
            frame_data <= shift;
            frame_perr <= perr;
            frame_ferr <= (state == st_stop) ? !rx_sync : ferr;
        end
    end

    assign rx_frame = '{valid: valid_q, data: frame_data,
                        parity_err: frame_perr, frame_err: frame_ferr};

    a_valid_pulse: assert property (@(posedge seq) disable iff (!arst_n)
        rx_frame.valid |=> !rx_frame.valid);

endmodule

// File: verilog/uart_tx.sv
`timescale 1ns/10ps

module uart_tx #(
    parameter int BRR_WIDTH = 16
) (
    input  logic                 seq,
    input  logic                 arst_n,
    input  uart_pkg::ctrl_t      ctrl,
    input  logic [BRR_WIDTH-1:0] brr,
    input  uart_pkg::tx_req_t    tx_req,
    output logic                 tx_ready,
    output logic                 tx
);

    typedef enum logic [2:0] {
        st_idle,
        st_start,
        st_data,
        st_parity,
        st_stop
    } state_t;

    state_t               state;
    logic [BRR_WIDTH-1:0] baud_cnt;
    logic [3:0]           bit_cnt;
    logic [3:0]           nbits;
    logic [7:0]           shift;
    logic                 par;
    logic                 bit_done;
    logic                 accept;
    logic                 load_bit;

    assign nbits    = uart_pkg::frame_bits(ctrl);
    assign bit_done = (brr == '0) || (baud_cnt == brr - BRR_WIDTH'(1));
    assign tx_ready = (state == st_idle) && ctrl.periph_en && ctrl.tx_en;
    assign accept   = tx_req.valid && tx_ready;

    // Next data bit goes onto the line
    assign load_bit = bit_done && ((state == st_start) ||
                                   (state == st_data && bit_cnt != nbits));

    always_ff @(posedge seq or negedge arst_n) begin
        if (!arst_n) begin
            state    <= st_idle;
            baud_cnt <= '0;
            bit_cnt  <= '0;
            tx       <= 1'b1;
        end else begin
            baud_cnt <= (state == st_idle || bit_done) ? '0 : baud_cnt + BRR_WIDTH'(1);
            if (load_bit) begin
                tx      <= shift[0]; // LSB first
                bit_cnt <= (state == st_start) ? 4'd1 : bit_cnt + 4'd1;
            end
            case (state)
                st_idle: begin
                    if (accept) begin
                        state <= st_start;
                        tx    <= 1'b0;
                    end
                end
                st_start: begin
                    if (bit_done) state <= st_data;
                end
                st_data: begin
                    if (bit_done && bit_cnt == nbits) begin
                        state   <= uart_pkg::has_parity(ctrl) ? st_parity : st_stop;
                        tx      <= uart_pkg::has_parity(ctrl) ? par : 1'b1;
                        bit_cnt <= '0;
                    end
                end
                st_parity: begin
                    if (bit_done) begin
                        state <= st_stop;
                        tx    <= 1'b1;
                    end
                end
                st_stop: begin
                    if (bit_done) begin
                        if (ctrl.two_stop && bit_cnt == '0) begin
                            bit_cnt <= 4'd1; // Second stop bit
                        end else begin
                            state <= st_idle;
                        end
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // Shift register and running parity
    always_ff @(posedge seq) begin
        if (accept) begin
            shift <= tx_req.data;
            par   <= (ctrl.parity == uart_pkg::parity_odd);
        end else if (load_bit) begin
            shift <= shift >> 1;
            par   <= par ^ shift[0];
        end
    end

    a_idle_high: assert property (@(posedge seq) disable iff (!arst_n)
        state == st_idle |-> tx);

endmodule

// File: verilog/uart_regs.sv
`timescale 1ns/10ps

module uart_regs #(
    parameter int BRR_WIDTH = 16
) (
    input  logic                   seq,
    input  logic                   arst_n,
    input  logic                   psel,
    input  logic                   penable,
    input  logic                   pwrite,
    input  uart_pkg::addr_t        paddr,
    input  uart_pkg::data_t        pwdata,
    input  logic [3:0]             pstrb,
    output uart_pkg::data_t        prdata,
    output logic                   pready,
    output logic                   pslverr,
    output uart_pkg::ctrl_t        ctrl,
    output logic [BRR_WIDTH-1:0]   brr,
    output uart_pkg::tx_req_t      tx_req,
    input  logic                   tx_ready,
    input  uart_pkg::rx_frame_t    rx_frame,
    output logic                   irq
);

    uart_pkg::ctrl_t      ctrl_q;
    uart_pkg::ctrl_t      ctrl_wr;
    uart_pkg::status_t    status_q;
    uart_pkg::status_t    ier_q;
    logic [BRR_WIDTH-1:0] brr_q;
    logic [7:0]           tx_buf;
    logic [7:0]           rx_buf;

    logic [11:0]     offs;
    logic            access;
    logic            sel_dr, sel_cr, sel_sr, sel_brr, sel_ier;
    logic            err;
    logic            wr;
    logic            rd;
    uart_pkg::data_t cur;
    uart_pkg::data_t merged;

    // Byte lanes with strobe low keep the old value
    function automatic uart_pkg::data_t merge_strb(uart_pkg::data_t old_val,
                                                   uart_pkg::data_t new_val,
                                                   logic [3:0] strb);
        uart_pkg::data_t res;
        res = old_val;
        for (int i = 0; i < 4; i++) begin
            if (strb[i]) begin
                res[8*i +: 8] = new_val[8*i +: 8];
            end
        end
        return res;
    endfunction

    assign access  = psel && penable;
    assign offs    = paddr[11:0]; // 4 KB window
    assign sel_dr  = offs == uart_pkg::reg_dr[11:0];
    assign sel_cr  = offs == uart_pkg::reg_cr[11:0];
    assign sel_sr  = offs == uart_pkg::reg_sr[11:0];
    assign sel_brr = offs == uart_pkg::reg_brr[11:0];
    assign sel_ier = offs == uart_pkg::reg_ier[11:0];

    // DR is locked while the peripheral is off
    assign err = access && ((sel_dr && !ctrl_q.periph_en) ||
                            !(sel_dr || sel_cr || sel_sr || sel_brr || sel_ier));
    assign wr  = access && pwrite && !err;
    assign rd  = access && !pwrite && !err;

    always_comb begin
        cur = '0;
        if (sel_dr) begin
            cur = {24'b0, rx_buf};
        end else if (sel_cr) begin
            cur = {20'b0, ctrl_q};
        end else if (sel_sr) begin
            cur = {27'b0, status_q};
        end else if (sel_brr) begin
            cur = uart_pkg::data_t'(brr_q);
        end else if (sel_ier) begin
            cur = {27'b0, ier_q};
        end
    end

    assign merged = merge_strb(cur, pwdata, pstrb);

    always_comb begin
        ctrl_wr       = merged[11:0];
        ctrl_wr.spare = 2'b00;
    end

    assign prdata  = rd ? cur : '0;
    assign pready  = 1'b1; // No wait states
    assign pslverr = err ? uart_pkg::resp_slverr : uart_pkg::resp_okay;

    always_ff @(posedge seq or negedge arst_n) begin
        if (!arst_n) begin
            ctrl_q <= '0;
            brr_q  <= '0;
            ier_q  <= '0;
        end else if (wr) begin
            if (sel_cr) ctrl_q <= ctrl_wr;
            if (sel_brr) brr_q <= merged[BRR_WIDTH-1:0];
            if (sel_ier) ier_q <= merged[4:0];
        end
    end

    always_ff @(posedge seq or negedge arst_n) begin
        if (!arst_n) begin
            status_q <= '{overrun: 1'b0, frame_err: 1'b0, parity_err: 1'b0,
                          rbf: 1'b0, tbe: 1'b1};
        end else begin
            // Write one to clear the error flags
            if (wr && sel_sr && pstrb[0]) begin
                if (pwdata[2]) status_q.parity_err <= 1'b0;
                if (pwdata[3]) status_q.frame_err <= 1'b0;
                if (pwdata[4]) status_q.overrun <= 1'b0;
            end
            if (rd && sel_dr) status_q.rbf <= 1'b0;
            if (tx_req.valid && tx_ready) status_q.tbe <= 1'b1; // Buffer free again
            if (wr && sel_dr) begin
                if (status_q.tbe) begin
                    status_q.tbe <= 1'b0;
                end else begin
                    status_q.overrun <= 1'b1; // Byte dropped
                end
            end
            if (rx_frame.valid) begin
                status_q.rbf <= 1'b1;
                if (status_q.rbf) status_q.overrun <= 1'b1;
                if (rx_frame.parity_err) status_q.parity_err <= 1'b1;
                if (rx_frame.frame_err) status_q.frame_err <= 1'b1;
            end
        end
    end

    // One-word buffers
    always_ff @(posedge seq) begin
        if (wr && sel_dr && status_q.tbe) tx_buf <= pwdata[7:0];
        if (rx_frame.valid) rx_buf <= rx_frame.data; // Newest byte wins
    end

    always_ff @(posedge seq or negedge arst_n) begin
        if (!arst_n) begin
            irq <= 1'b0;
        end else begin
            irq <= |(status_q & ier_q);
        end
    end

    assign ctrl   = ctrl_q;
    assign brr    = brr_q;
    assign tx_req = '{valid: !status_q.tbe, data: tx_buf};

    a_apb_ready: assert property (@(posedge seq) disable iff (!arst_n)
        psel && penable |-> pready);

endmodule

// File: verilog/uart_pkg.sv
package uart_pkg;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] data_t;

    // Register offsets
    localparam addr_t reg_dr  = 32'h0000_0000;
    localparam addr_t reg_cr  = 32'h0000_0004;
    localparam addr_t reg_sr  = 32'h0000_0008;
    localparam addr_t reg_brr = 32'h0000_000C;
    localparam addr_t reg_ier = 32'h0000_0010;

    // Value on pslverr
    localparam logic resp_okay   = 1'b0;
    localparam logic resp_slverr = 1'b1;

    typedef enum logic [1:0] {
        parity_none = 2'd0,
        parity_even = 2'd1,
        parity_odd  = 2'd2
    } parity_e;

    typedef struct packed {
        logic [3:0] data_bits; // 5 to 8
        logic [1:0] spare;     // Not stored, reads as zero
        logic       two_stop;
        parity_e    parity;
        logic       rx_en;
        logic       tx_en;
        logic       periph_en;
    } ctrl_t;

    // Same layout for status and interrupt enable
    typedef struct packed {
        logic overrun;
        logic frame_err;
        logic parity_err;
        logic rbf;
        logic tbe;
    } status_t;

    typedef struct packed {
        logic       valid;
        logic [7:0] data;
    } tx_req_t;

    typedef struct packed {
        logic       valid;
        logic [7:0] data;
        logic       parity_err;
        logic       frame_err;
    } rx_frame_t;

    // Data bits per frame, illegal settings pulled into 5..8
    function automatic logic [3:0] frame_bits(ctrl_t c);
        if (c.data_bits < 4'd5) begin
            return 4'd5;
        end
        if (c.data_bits > 4'd8) begin
            return 4'd8;
        end
        return c.data_bits;
    endfunction

    function automatic logic has_parity(ctrl_t c);
        return (c.parity == parity_even) || (c.parity == parity_odd);
    endfunction

endpackage
